//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs the trace and judges the result from the log
cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -f tb.f --top-module l2_miss_pipeline_tb -Mdir obj_dir; then
	echo "build failed"
	exit 1
fi

if ! ./obj_dir/Vl2_miss_pipeline_tb > "$log" 2>&1; then
	cat "$log"
	echo "simulation exited with an error status"
	exit 1
fi

cat "$log"
if grep -qx "Test passed" "$log"; then
	exit 0
fi
echo "pass message missing from $log"
exit 1

//--- tb.f
verilog/l2_defs_pkg.sv
verilog/cam.sv
verilog/tag_check_stage.sv
verilog/pending_miss_stage.sv
verilog/miss_queue.sv
verilog/l2_miss_pipeline.sv
tests/l2_miss_pipeline_tb.sv

//--- tests/l2_miss_pipeline_tb.sv
// testbench for the L2 miss pipeline with trace-driven requests and acks, response checks, watchdog
`timescale 1ns/100ps
`default_nettype none

module l2_miss_pipeline_tb;

	import l2_defs_pkg::*;

	localparam int clk_period = 20;
	localparam int reset_cycles = 3;
	// spare cycles on top of the trace for reset and pipeline drain
	localparam int margin_cycles = 20;

	typedef enum logic [1:0] {op_lookup, op_fill, op_ack, op_idle} step_op_t;

	// one trace step, for an ack the address is the expected head of the memory queue
	typedef struct packed {
		step_op_t op;
		logic [line_addr_width-1:0] address;
		result_kind_t kind;
		logic [7:0] test_id;
	} step_t;

	// what the response two cycles after a driven cycle has to look like
	typedef struct packed {
		logic valid;
		logic [line_addr_width-1:0] address;
		result_kind_t kind;
		logic [7:0] test_id;
	} expect_t;

	logic clk;
	logic reset;
	logic req_valid;
	l2_req_t req;
	logic mem_req_ack;
	logic resp_valid;
	l2_resp_t resp;
	logic mem_req_valid;
	logic [line_addr_width-1:0] mem_req_address;

	step_t steps[$];
	string test_names[$];
	expect_t in_flight[$];
	bit trace_loaded;

	// expected values that travel alongside the driven inputs
	result_kind_t drive_kind;
	logic [7:0] drive_test;
	logic [line_addr_width-1:0] ack_address;

	// memory requests that should sit in the queue during the current cycle
	int queued_misses;

	l2_miss_pipeline u_dut (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.resp_valid(resp_valid),
		.resp(resp),
		.mem_req_valid(mem_req_valid),
		.mem_req_address(mem_req_address),
		.mem_req_ack(mem_req_ack));

	initial
	begin
		clk = 1'b0;
		forever
			#(clk_period / 2) clk = ~clk;
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input logic [7:0] test_id, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		stop_with_failure($sformatf("error %s %s expected 0x%0h actual 0x%0h",
			test_names[test_id], what, expected, actual));
	endtask

	// trace kind names follow the result kinds of the pending-miss stage
	task automatic parse_kind(input string name, output result_kind_t kind);
		kind = kind_hit;
		if (name == "hit")
			kind = kind_hit;
		else if (name == "new")
			kind = kind_miss_new;
		else if (name == "dup")
			kind = kind_miss_duplicate;
		else if (name == "fill")
			kind = kind_fill_done;
		else
			stop_with_failure($sformatf("unknown result kind %s in the trace", name));
	endtask

	task automatic load_trace();
		int fd;
		int ch;
		string op;
		string name;
		step_t step;
		result_kind_t kind;
		logic [line_addr_width-1:0] address;
		fd = $fopen("tests/l2_trace.txt", "r");
		if (fd == 0)
			stop_with_failure("could not open the trace file tests/l2_trace.txt");
		// steps before the first test line belong to the reset phase
		test_names.push_back("reset");
		while ($fscanf(fd, "%s", op) == 1)
		begin
			step = '0;
			step.test_id = 8'(test_names.size() - 1);
			if (op[0] == "#")
			begin
				ch = 0;
				while (ch != 10 && ch != -1)
					ch = $fgetc(fd);
			end
			else if (op == "test")
			begin
				if ($fscanf(fd, "%s", name) != 1)
					stop_with_failure("a test line in the trace has no name");
				test_names.push_back(name);
			end
			else if (op == "lookup" || op == "fill")
			begin
				if ($fscanf(fd, "%h %s", address, name) != 2)
					stop_with_failure("a request line in the trace is incomplete");
				parse_kind(name, kind);
				step.op = (op == "fill") ? op_fill : op_lookup;
				step.address = address;
				step.kind = kind;
				steps.push_back(step);
			end
			else if (op == "ack")
			begin
				if ($fscanf(fd, "%h", address) != 1)
					stop_with_failure("an ack line in the trace has no address");
				step.op = op_ack;
				step.address = address;
				steps.push_back(step);
			end
			else if (op == "idle")
			begin
				step.op = op_idle;
				steps.push_back(step);
			end
			else
				stop_with_failure($sformatf("unknown operation %s in the trace", op));
		end
		$fclose(fd);
	endtask

	// stimulus, one trace step per clock, all inputs change right after the rising edge
	initial
	begin
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		mem_req_ack = 1'b0;
		drive_kind = kind_hit;
		drive_test = '0;
		ack_address = '0;
		queued_misses = 0;
		trace_loaded = 1'b0;
		load_trace();
		trace_loaded = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
		foreach (steps[i])
		begin
			@(posedge clk);
			req_valid <= (steps[i].op == op_lookup) || (steps[i].op == op_fill);
			req.address <= steps[i].address;
			req.is_fill <= (steps[i].op == op_fill);
			mem_req_ack <= (steps[i].op == op_ack);
			ack_address <= steps[i].address;
			drive_kind <= steps[i].kind;
			drive_test <= steps[i].test_id;
		end
		@(posedge clk);
		req_valid <= 1'b0;
		mem_req_ack <= 1'b0;
		repeat (4) @(posedge clk);
		// every miss was acked, so a leftover entry means a line went to memory twice
		@(negedge clk);
		assert (!mem_req_valid)
		else stop_with_failure("memory queue still holds a request after the last ack");
		@(posedge clk);
		$display("Test passed");
		$finish;
	end

	// outputs are sampled at the falling edge, half a cycle away from any change
	always @(negedge clk)
	begin
		expect_t entry;
		expect_t due;
		entry.valid = req_valid;
		entry.address = req.address;
		entry.kind = drive_kind;
		entry.test_id = drive_test;
		in_flight.push_back(entry);
		// the queue fills one edge after a new miss is reported and drains one edge after an ack
		assert (mem_req_valid == (queued_misses != 0))
		else report_mismatch(drive_test, "memory request valid",
			32'(queued_misses != 0), 32'(mem_req_valid));
		// the entry pushed two falling edges ago is due now
		if (in_flight.size() > 2)
		begin
			due = in_flight.pop_front();
			assert (resp_valid == due.valid)
			else report_mismatch(due.test_id, "resp_valid", 32'(due.valid), 32'(resp_valid));
			if (due.valid)
			begin
				assert (resp.address == due.address)
				else report_mismatch(due.test_id, "response address",
					32'(due.address), 32'(resp.address));
				assert (resp.kind == due.kind)
				else report_mismatch(due.test_id, "response kind",
					32'(due.kind), 32'(resp.kind));
			end
			// a reported new miss reaches memory from the next cycle on
			if (due.valid && due.kind == kind_miss_new)
				queued_misses++;
		end
		// the ack pops whatever memory sees during this cycle
		if (mem_req_ack)
		begin
			assert (mem_req_valid)
			else stop_with_failure($sformatf("no memory request was pending for the ack in %s",
				test_names[drive_test]));
			assert (mem_req_address == ack_address)
			else report_mismatch(drive_test, "memory request address",
				32'(ack_address), 32'(mem_req_address));
			queued_misses--;
		end
	end

	// watchdog sized from the trace once it is loaded
	initial
	begin
		wait (trace_loaded);
		#((steps.size() + reset_cycles + margin_cycles) * clk_period);
		stop_with_failure("the run timed out before the trace finished");
	end

endmodule

`default_nettype wire

//--- tests/l2_trace.txt
# columns: lookup|fill <line address hex> <hit|new|dup|fill>, ack <expected memory address hex>, idle
# a test line names the steps after it, a # token starts a comment
test miss_order
lookup 0000041 new
lookup 0000082 new
lookup 0000104 new
lookup 0000104 dup # very next cycle
idle
ack 0000041
lookup 0000082 dup
ack 0000082
ack 0000104
lookup 0000041 dup # acked but not filled yet
test fill_then_hit
fill 0000041 fill
lookup 0000041 hit
fill 0000082 fill
lookup 0000082 hit
test set_replace
fill 0000104 fill
lookup 0000144 new # same set as 0000104
idle
idle
ack 0000144
fill 0000144 fill
lookup 0000104 new
lookup 0000144 hit
idle
idle
ack 0000104
fill 0000104 fill
test entry_reuse
lookup 3ffffc5 new
lookup 1234567 new
lookup 2000008 new
ack 3ffffc5
ack 1234567
ack 2000008
fill 3ffffc5 fill
lookup 3ffffc5 hit
fill 1234567 fill
fill 2000008 fill

//--- verilog/cam.sv
// content-addressable key store with combinational search and single-entry registered update
`timescale 1ns/100ps
`default_nettype none

module cam
	#(parameter int num_entries = 8,
	parameter int key_width = 26)
	(input logic clk,
	input logic reset,
	input logic [key_width-1:0] lookup_key,
	output logic lookup_hit,
	output logic [$clog2(num_entries)-1:0] lookup_index,
	input logic update_en,
	input logic [$clog2(num_entries)-1:0] update_index,
	input logic [key_width-1:0] update_key,
	input logic update_valid);

	localparam int index_width = $clog2(num_entries);

	// each entry holds a key and a valid bit, only valid entries take part in the search
	logic [key_width-1:0] entry_key[num_entries];
	logic [num_entries-1:0] entry_valid;

	// compare the search key against every entry at once
	// the caller never stores the same key twice, so at most one entry matches
	always_comb
	begin
		lookup_hit = 1'b0;
		lookup_index = '0;
		for (int i = 0; i < num_entries; i++)
		begin
			if (entry_valid[i] && entry_key[i] == lookup_key)
			begin
				lookup_hit = 1'b1;
				lookup_index = index_width'(i);
			end
		end
	end

	// valid bits start cleared so an empty store never reports a hit
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			entry_valid <= '0;
		else if (update_en)
			entry_valid[update_index] <= update_valid;
	end

	// keys are only looked at while their valid bit is set
	always_ff @(posedge clk)
	begin
		if (update_en)
			entry_key[update_index] <= update_key;
	end

endmodule

`default_nettype wire

//--- verilog/l2_defs_pkg.sv
// package with L2 miss pipeline widths, table sizes, request, result and response types
`default_nettype none

package l2_defs_pkg;

	// a line address names one cache line in system memory
	localparam int line_addr_width = 26;

	// the low address bits select one set of the direct-mapped tag store
	localparam int set_index_width = 6;
	localparam int num_sets = 64;

	// the tag is everything above the set index
	localparam int tag_width = 20;

	// depth of the pending-miss tracker, which also sizes the memory request queue
	localparam int pending_entries = 8;
	localparam int pending_index_width = 3;

	// one incoming request, either a lookup or a fill returning from memory
	typedef struct packed {
		logic [line_addr_width-1:0] address;
		logic is_fill;
	} l2_req_t;

	// classification reported for every request that leaves stage two
	typedef enum logic [1:0] {
		// tag matched on a lookup
		kind_hit = 2'd0,
		// lookup missed and no fetch is pending, so memory gets a request
		kind_miss_new = 2'd1,
		// lookup missed but the line is already being fetched
		kind_miss_duplicate = 2'd2,
		// a fill went through both stages
		kind_fill_done = 2'd3
	} result_kind_t;

	// what stage one hands to stage two
	typedef struct packed {
		l2_req_t req;
		// meaningless for fills
		logic tag_hit;
	} tag_result_t;

	// result presented to the requester
	typedef struct packed {
		logic [line_addr_width-1:0] address;
		result_kind_t kind;
	} l2_resp_t;

endpackage

`default_nettype wire

//--- verilog/l2_miss_pipeline.sv
// top level of the L2 miss front end, tag stage, pending-miss stage and memory request queue
`timescale 1ns/100ps
`default_nettype none

module l2_miss_pipeline
	(input logic clk,
	input logic reset,
	input logic req_valid,
	input l2_defs_pkg::l2_req_t req,
	output logic resp_valid,
	output l2_defs_pkg::l2_resp_t resp,
	output logic mem_req_valid,
	output logic [l2_defs_pkg::line_addr_width-1:0] mem_req_address,
	input logic mem_req_ack);

	import l2_defs_pkg::*;

	// stage one to stage two
	logic stage_one_valid;
	tag_result_t stage_one_data;

	// stage two to the memory request queue
	logic enqueue;
	logic [line_addr_width-1:0] enqueue_address;

	// first register stage checks the tag store
	tag_check_stage u_tag_check (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.out_valid(stage_one_valid),
		.out_data(stage_one_data));

	// second register stage tracks outstanding fetches and reports the result
	pending_miss_stage u_pending_miss (
		.clk(clk),
		.reset(reset),
		.in_valid(stage_one_valid),
		.in_data(stage_one_data),
		.resp_valid(resp_valid),
		.resp(resp),
		.enqueue(enqueue),
		.enqueue_address(enqueue_address));

	// queue depth matches the tracker so every outstanding miss has a slot
	miss_queue #(
		.depth(pending_entries)
	) u_miss_queue (
		.clk(clk),
		.reset(reset),
		.enqueue(enqueue),
		.enqueue_address(enqueue_address),
		.mem_req_ack(mem_req_ack),
		.mem_req_valid(mem_req_valid),
		.mem_req_address(mem_req_address));

endmodule

`default_nettype wire

//--- verilog/miss_queue.sv
// circular FIFO of new miss line addresses waiting for system memory
`timescale 1ns/100ps
`default_nettype none

module miss_queue
	#(parameter int depth = l2_defs_pkg::pending_entries)
	(input logic clk,
	input logic reset,
	input logic enqueue,
	input logic [l2_defs_pkg::line_addr_width-1:0] enqueue_address,
	input logic mem_req_ack,
	output logic mem_req_valid,
	output logic [l2_defs_pkg::line_addr_width-1:0] mem_req_address);

	import l2_defs_pkg::*;

	localparam int ptr_width = $clog2(depth);
	localparam int count_width = $clog2(depth + 1);

	logic [line_addr_width-1:0] entries[depth];
	logic [ptr_width-1:0] rd_ptr;
	logic [ptr_width-1:0] wr_ptr;
	logic [count_width-1:0] count;
	logic pop;

	// memory sees the oldest address for as long as anything is queued
	assign mem_req_valid = (count != '0);
	assign mem_req_address = entries[rd_ptr];

	// an ack against an empty queue has nothing to remove
	assign pop = mem_req_ack && mem_req_valid;

	// pointers wrap explicitly so depth need not be a power of two
	// the requester rules keep a push from ever landing on a full queue
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (enqueue)
				wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;

			// push and pop in one cycle leave the occupancy unchanged
			if (enqueue && !pop)
				count <= count + 1'b1;
			else if (pop && !enqueue)
				count <= count - 1'b1;
		end
	end

	// slot written one edge after the pulse, so memory sees it the cycle after the response
	always_ff @(posedge clk)
	begin
		if (enqueue)
			entries[wr_ptr] <= enqueue_address;
	end

endmodule

`default_nettype wire

//--- verilog/pending_miss_stage.sv
// stage two of the L2 miss pipeline, pending-miss tracker and result classification
`timescale 1ns/100ps
`default_nettype none

module pending_miss_stage
	(input logic clk,
	input logic reset,
	input logic in_valid,
	input l2_defs_pkg::tag_result_t in_data,
	output logic resp_valid,
	output l2_defs_pkg::l2_resp_t resp,
	output logic enqueue,
	output logic [l2_defs_pkg::line_addr_width-1:0] enqueue_address);

	import l2_defs_pkg::*;

	// a set bit marks a tracker entry that holds no pending line
	logic [pending_entries-1:0] empty_mask;
	logic [pending_index_width-1:0] next_empty;

	// result of searching the tracker with the incoming address
	logic cam_hit;
	logic [pending_index_width-1:0] cam_hit_index;

	logic is_fill;
	logic new_miss;
	logic free_entry;
	result_kind_t kind;

	assign is_fill = in_data.req.is_fill;

	// a lookup that missed the tags and found no pending fetch starts a new one
	assign new_miss = in_valid && !is_fill && !in_data.tag_hit && !cam_hit;

	// a fill retires the pending entry for its line, if there is one
	assign free_entry = in_valid && is_fill && cam_hit;

	// lowest empty entry wins
	// the requester keeps at most pending_entries misses open,
	// so an empty entry always exists when a new miss arrives
	always_comb
	begin
		next_empty = '0;
		for (int i = pending_entries - 1; i >= 0; i--)
		begin
			if (empty_mask[i])
				next_empty = pending_index_width'(i);
		end
	end

	// fills take priority, then tag hits, then the tracker decides
	always_comb
	begin
		if (is_fill)
			kind = kind_fill_done;
		else if (in_data.tag_hit)
			kind = kind_hit;
		else if (cam_hit)
			kind = kind_miss_duplicate;
		else
			kind = kind_miss_new;
	end

	// the tracker entry is written at the edge that registers the result,
	// so a repeat miss in the very next cycle already matches
	cam #(
		.num_entries(pending_entries),
		.key_width(line_addr_width)
	) u_pending_cam (
		.clk(clk),
		.reset(reset),
		.lookup_key(in_data.req.address),
		.lookup_hit(cam_hit),
		.lookup_index(cam_hit_index),
		.update_en(new_miss || free_entry),
		.update_index(free_entry ? cam_hit_index : next_empty),
		.update_key(in_data.req.address),
		.update_valid(new_miss));

	// control state of the tracker and the output strobes
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			empty_mask <= '1;
			resp_valid <= 1'b0;
			enqueue <= 1'b0;
		end
		else
		begin
			resp_valid <= in_valid;
			enqueue <= new_miss;
			if (free_entry)
				empty_mask[cam_hit_index] <= 1'b1;
			else if (new_miss)
				empty_mask[next_empty] <= 1'b0;
		end
	end

	// response payload follows the strobe
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			resp.address <= in_data.req.address;
			resp.kind <= kind;
		end
	end

	// the queue takes the same line that the response reports
	assign enqueue_address = resp.address;

endmodule

`default_nettype wire

//--- verilog/tag_check_stage.sv
// stage one of the L2 miss pipeline, direct-mapped tag store lookup and fill install
`timescale 1ns/100ps
`default_nettype none

module tag_check_stage
	(input logic clk,
	input logic reset,
	input logic req_valid,
	input l2_defs_pkg::l2_req_t req,
	output logic out_valid,
	output l2_defs_pkg::tag_result_t out_data);

	import l2_defs_pkg::*;

	// one tag and one valid bit per set
	logic [tag_width-1:0] set_tag[num_sets];
	logic [num_sets-1:0] set_valid;

	// fields of the incoming line address
	logic [set_index_width-1:0] req_set;
	logic [tag_width-1:0] req_tag;

	logic tag_hit;
	logic install;

	// low bits pick the set and the rest is compared as the tag
	assign req_set = req.address[set_index_width-1:0];
	assign req_tag = req.address[line_addr_width-1 -: tag_width];

	// a set only hits once a fill has installed a line there
	assign tag_hit = set_valid[req_set] && (set_tag[req_set] == req_tag);

	// a fill claims its set and evicts whatever line lived there before
	assign install = req_valid && req.is_fill;

	// control state
	// the valid bit goes up at the same edge that passes the fill on,
	// so a lookup one cycle later already sees the new line
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			set_valid <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= req_valid;
			if (install)
				set_valid[req_set] <= 1'b1;
		end
	end

	// tag storage and the registered request for stage two
	always_ff @(posedge clk)
	begin
		if (install)
			set_tag[req_set] <= req_tag;

		// payload only moves when a request is present
		if (req_valid)
		begin
			out_data.req <= req;
			out_data.tag_hit <= tag_hit;
		end
	end

endmodule

`default_nettype wire
